// ==== tcp_pkg.sv ====
package tcp_pkg;

    localparam int N_CONN    = 4;
    localparam int CONN_ID_W = 2;

    // TIME_WAIT stands in for 2MSL.
    localparam int TIME_WAIT_CYCLES = 4;
    localparam int TW_CNT_W         = $clog2(TIME_WAIT_CYCLES);

    // Host register word addresses.
    localparam logic [1:0] REG_ENABLE = 2'd0;
    localparam logic [1:0] REG_CTRL   = 2'd1;
    localparam logic [1:0] REG_STATUS = 2'd2;

    // Close request bits sit in the upper half of REG_CTRL.
    localparam int CTRL_CLOSE_LSB = 16;

    typedef enum logic [1:0] {
        RX_MSG_NONE,
        RX_MSG_RECV_SYNACK,
        RX_MSG_RECV_ACK,
        RX_MSG_RECV_FIN
    } rx_msg_t;

    typedef enum logic [1:0] {
        TX_CTRL_NOP,
        TX_CTRL_SEND_SYN,
        TX_CTRL_SEND_ACK,
        TX_CTRL_SEND_FIN
    } tx_ctrl_t;

    typedef enum logic [3:0] {
        IDLE = 4'd0,
        SYN_SENT_1,
        SYN_SENT_2,
        ESTABLISHED,
        WAIT_CLOSE,
        LAST_ACK,
        TIME_WAIT,
        FIN_WAIT_1,
        FIN_WAIT_2
    } conn_state_e;

    typedef struct packed {
        logic [CONN_ID_W-1:0] conn_id;
        logic                 syn;
        logic                 ack;
        logic                 fin;
    } seg_hdr_t;

    // Connection 0 occupies the low nibble.
    typedef conn_state_e [N_CONN-1:0] conn_state_vec_t;

endpackage

// ==== tcp_conn_fsm.sv ====
`timescale 1ns/1ps

module tcp_conn_fsm (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_enable,
    input  logic                 i_open,
    output logic                 o_open_clr,
    input  logic                 i_close,
    output logic                 o_close_clr,
    output tcp_pkg::tx_ctrl_t    o_tx_ctrl,
    output logic                 o_tx_ctrl_valid,
    input  logic                 i_tx_ctrl_ack,
    input  tcp_pkg::rx_msg_t     i_rx_msg,
    input  logic                 i_rx_msg_valid,
    output logic                 o_rx_msg_ack,
    output tcp_pkg::conn_state_e o_state
);
    import tcp_pkg::*;

    conn_state_e         state_q;
    conn_state_e         state_d;
    logic                peer_fin_q;
    logic                peer_fin_d;
    logic                fin_req_q;
    logic [TW_CNT_W-1:0] tw_cnt_q;
    logic                fin_msg;
    logic                ack_msg;

    // Messages are always taken in the cycle they show up.
    assign o_rx_msg_ack = i_rx_msg_valid;
    assign fin_msg      = i_rx_msg_valid && (i_rx_msg == RX_MSG_RECV_FIN);
    assign ack_msg      = i_rx_msg_valid && (i_rx_msg == RX_MSG_RECV_ACK);
    assign o_state      = state_q;

    always_comb begin
        state_d         = state_q;
        peer_fin_d      = peer_fin_q;
        o_tx_ctrl       = TX_CTRL_NOP;
        o_tx_ctrl_valid = 1'b0;
        o_open_clr      = 1'b0;
        o_close_clr     = 1'b0;

        case (state_q)
            IDLE: begin
                if (i_open) begin
                    o_tx_ctrl       = TX_CTRL_SEND_SYN;
                    o_tx_ctrl_valid = 1'b1;
                    if (i_tx_ctrl_ack) begin
                        state_d = SYN_SENT_1;
                    end
                end
            end
            SYN_SENT_1: begin
                if (i_rx_msg_valid && (i_rx_msg == RX_MSG_RECV_SYNACK)) begin
                    state_d = SYN_SENT_2;
                end
            end
            SYN_SENT_2: begin
                o_tx_ctrl       = TX_CTRL_SEND_ACK;
                o_tx_ctrl_valid = 1'b1;
                if (i_tx_ctrl_ack) begin
                    state_d    = ESTABLISHED;
                    o_open_clr = 1'b1;
                end
            end
            ESTABLISHED: begin
                if (fin_msg) begin
                    peer_fin_d = 1'b1;
                end
                // Whichever request went out first keeps the slot.
                if (fin_req_q || (i_close && !peer_fin_q)) begin
                    o_tx_ctrl       = TX_CTRL_SEND_FIN;
                    o_tx_ctrl_valid = 1'b1;
                    if (i_tx_ctrl_ack) begin
                        state_d     = FIN_WAIT_1;
                        o_close_clr = 1'b1;
                    end
                end else if (peer_fin_q) begin
                    o_tx_ctrl       = TX_CTRL_SEND_ACK;
                    o_tx_ctrl_valid = 1'b1;
                    if (i_tx_ctrl_ack) begin
                        state_d    = WAIT_CLOSE;
                        peer_fin_d = 1'b0;
                    end
                end
            end
            WAIT_CLOSE: begin
                o_tx_ctrl       = TX_CTRL_SEND_FIN;
                o_tx_ctrl_valid = 1'b1;
                if (i_tx_ctrl_ack) begin
                    state_d     = LAST_ACK;
                    o_close_clr = 1'b1;
                end
            end
            LAST_ACK: begin
                if (ack_msg) begin
                    state_d = IDLE;
                end
            end
            FIN_WAIT_1, FIN_WAIT_2: begin
                if (fin_msg) begin
                    peer_fin_d = 1'b1;
                end
                if (peer_fin_q) begin
                    o_tx_ctrl       = TX_CTRL_SEND_ACK;
                    o_tx_ctrl_valid = 1'b1;
                    if (i_tx_ctrl_ack) begin
                        state_d    = TIME_WAIT;
                        peer_fin_d = 1'b0;
                    end
                end else if (ack_msg && (state_q == FIN_WAIT_1)) begin
                    state_d = FIN_WAIT_2;
                end
            end
            TIME_WAIT: begin
                if (tw_cnt_q == TW_CNT_W'(TIME_WAIT_CYCLES - 1)) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase

        // No requests while the engine is off.
        if (!i_enable) begin
            o_tx_ctrl_valid = 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst || !i_enable) begin
            state_q    <= IDLE;
            peer_fin_q <= 1'b0;
            fin_req_q  <= 1'b0;
            tw_cnt_q   <= '0;
        end else begin
            state_q    <= state_d;
            peer_fin_q <= peer_fin_d;
            fin_req_q  <= (state_q == ESTABLISHED) && o_tx_ctrl_valid
                          && (o_tx_ctrl == TX_CTRL_SEND_FIN) && !i_tx_ctrl_ack;
            if (state_q == TIME_WAIT) begin
                tw_cnt_q <= tw_cnt_q + 1'b1;
            end else begin
                tw_cnt_q <= '0;
            end
        end
    end

    a_req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        o_tx_ctrl_valid && !i_tx_ctrl_ack |=>
            !i_enable || (o_tx_ctrl_valid && $stable(o_tx_ctrl)));

    a_time_wait_limit: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(state_q == TIME_WAIT) |-> ##TIME_WAIT_CYCLES (state_q != TIME_WAIT));

endmodule

// ==== tcp_rx_classifier.sv ====
`timescale 1ns/1ps

module tcp_rx_classifier (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  tcp_pkg::seg_hdr_t            i_rx_seg,
    input  logic                         i_rx_seg_valid,
    output logic                         o_rx_seg_ready,
    output tcp_pkg::rx_msg_t             o_msg,
    output logic [tcp_pkg::N_CONN-1:0]   o_msg_valid,
    input  logic [tcp_pkg::N_CONN-1:0]   i_msg_ack
);
    import tcp_pkg::*;

    logic                 full_q;
    logic [CONN_ID_W-1:0] id_q;
    rx_msg_t              msg_q;
    rx_msg_t              msg_d;
    logic                 consume;
    logic                 load;

    // FIN wins over any other flag.
    always_comb begin
        if (i_rx_seg.fin) begin
            msg_d = RX_MSG_RECV_FIN;
        end else if (i_rx_seg.syn && i_rx_seg.ack) begin
            msg_d = RX_MSG_RECV_SYNACK;
        end else if (i_rx_seg.ack) begin
            msg_d = RX_MSG_RECV_ACK;
        end else begin
            msg_d = RX_MSG_NONE;
        end
    end

    assign consume        = full_q && i_msg_ack[id_q];
    assign o_rx_seg_ready = !full_q || consume;
    // Headers with no useful flags are taken and dropped here.
    assign load           = i_rx_seg_valid && o_rx_seg_ready && (msg_d != RX_MSG_NONE);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (consume) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (load) begin
            id_q  <= i_rx_seg.conn_id;
            msg_q <= msg_d;
        end
    end

    assign o_msg = msg_q;

    always_comb begin
        for (int i = 0; i < N_CONN; i++) begin
            o_msg_valid[i] = full_q && (id_q == CONN_ID_W'(i));
        end
    end

    // The addressed connection takes its message in the cycle it is shown.
    a_msg_taken: assert property (@(posedge i_clk) disable iff (i_rst)
        full_q |-> i_msg_ack[id_q]);

endmodule

// ==== tcp_tx_arbiter.sv ====
`timescale 1ns/1ps

module tcp_tx_arbiter (
    input  logic                                  i_clk,
    input  logic                                  i_rst,
    input  tcp_pkg::tx_ctrl_t [tcp_pkg::N_CONN-1:0] i_req,
    input  logic [tcp_pkg::N_CONN-1:0]            i_req_valid,
    output logic [tcp_pkg::N_CONN-1:0]            o_req_ack,
    output tcp_pkg::seg_hdr_t                     o_tx_seg,
    output logic                                  o_tx_seg_valid,
    input  logic                                  i_tx_seg_ready
);
    import tcp_pkg::*;

    logic [CONN_ID_W-1:0] ptr_q;
    logic [CONN_ID_W-1:0] cand [N_CONN];
    logic [CONN_ID_W-1:0] gnt_idx;
    logic                 gnt_found;
    logic                 load_en;
    logic                 valid_q;
    seg_hdr_t             seg_d;
    seg_hdr_t             seg_q;

    // Search starts at the connection after the last winner.
    always_comb begin
        gnt_found = 1'b0;
        gnt_idx   = ptr_q;
        for (int i = 0; i < N_CONN; i++) begin
            cand[i] = ptr_q + CONN_ID_W'(i);
            if (!gnt_found && i_req_valid[cand[i]]) begin
                gnt_found = 1'b1;
                gnt_idx   = cand[i];
            end
        end
    end

    // Output register is free when empty or being drained.
    assign load_en   = !valid_q || i_tx_seg_ready;
    assign o_req_ack = (load_en && gnt_found) ? (N_CONN'(1) << gnt_idx) : '0;

    always_comb begin
        seg_d.conn_id = gnt_idx;
        seg_d.syn     = (i_req[gnt_idx] == TX_CTRL_SEND_SYN);
        seg_d.ack     = (i_req[gnt_idx] == TX_CTRL_SEND_ACK)
                        || (i_req[gnt_idx] == TX_CTRL_SEND_FIN);
        seg_d.fin     = (i_req[gnt_idx] == TX_CTRL_SEND_FIN);
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
            ptr_q   <= '0;
        end else if (load_en) begin
            valid_q <= gnt_found;
            if (gnt_found) begin
                ptr_q <= gnt_idx + CONN_ID_W'(1);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (load_en && gnt_found) begin
            seg_q <= seg_d;
        end
    end

    assign o_tx_seg       = seg_q;
    assign o_tx_seg_valid = valid_q;

    // Every grant goes to a connection that is asking.
    a_ack_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot0(o_req_ack) && ((o_req_ack & ~i_req_valid) == '0));

    a_out_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        o_tx_seg_valid && !i_tx_seg_ready |=> o_tx_seg_valid && $stable(o_tx_seg));

endmodule

// ==== tcp_host_regs.sv ====
`timescale 1ns/1ps

module tcp_host_regs (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_wb_cyc,
    input  logic                             i_wb_stb,
    input  logic                             i_wb_we,
    input  logic [1:0]                       i_wb_adr,
    input  logic [31:0]                      i_wb_dat,
    output logic [31:0]                      o_wb_dat,
    output logic                             o_wb_ack,
    output logic                             o_enable,
    output logic [tcp_pkg::N_CONN-1:0]       o_open,
    output logic [tcp_pkg::N_CONN-1:0]       o_close,
    input  logic [tcp_pkg::N_CONN-1:0]       i_open_clr,
    input  logic [tcp_pkg::N_CONN-1:0]       i_close_clr,
    input  tcp_pkg::conn_state_vec_t         i_state
);
    import tcp_pkg::*;

    logic              ack_q;
    logic              enable_q;
    logic [N_CONN-1:0] open_q;
    logic [N_CONN-1:0] close_q;
    logic [N_CONN-1:0] open_set;
    logic [N_CONN-1:0] close_set;
    logic [31:0]       rd_data;
    logic [31:0]       rd_q;
    logic              access;
    logic              wr_en;

    // One access per strobe; ack drops the cycle after it rises.
    assign access    = i_wb_cyc && i_wb_stb && !ack_q;
    assign wr_en     = access && i_wb_we;
    assign open_set  = (wr_en && i_wb_adr == REG_CTRL) ? i_wb_dat[N_CONN-1:0] : '0;
    assign close_set = (wr_en && i_wb_adr == REG_CTRL)
                       ? i_wb_dat[CTRL_CLOSE_LSB +: N_CONN] : '0;

    always_comb begin
        rd_data = '0;
        case (i_wb_adr)
            REG_ENABLE: rd_data[0] = enable_q;
            REG_CTRL: begin
                rd_data[N_CONN-1:0]               = open_q;
                rd_data[CTRL_CLOSE_LSB +: N_CONN] = close_q;
            end
            REG_STATUS: rd_data[$bits(conn_state_vec_t)-1:0] = i_state;
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack_q    <= 1'b0;
            enable_q <= 1'b0;
            open_q   <= '0;
            close_q  <= '0;
        end else begin
            ack_q <= access;
            if (wr_en && i_wb_adr == REG_ENABLE) begin
                enable_q <= i_wb_dat[0];
            end
            // A set in the same cycle beats the clear.
            open_q  <= (open_q & ~i_open_clr) | open_set;
            close_q <= (close_q & ~i_close_clr) | close_set;
        end
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            rd_q <= rd_data;
        end
    end

    assign o_wb_ack = ack_q;
    assign o_wb_dat = rd_q;
    assign o_enable = enable_q;
    assign o_open   = open_q;
    assign o_close  = close_q;

endmodule

// ==== tcp_conn_engine.sv ====
`timescale 1ns/1ps

module tcp_conn_engine (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_wb_cyc,
    input  logic              i_wb_stb,
    input  logic              i_wb_we,
    input  logic [1:0]        i_wb_adr,
    input  logic [31:0]       i_wb_dat,
    output logic [31:0]       o_wb_dat,
    output logic              o_wb_ack,
    input  tcp_pkg::seg_hdr_t i_rx_seg,
    input  logic              i_rx_seg_valid,
    output logic              o_rx_seg_ready,
    output tcp_pkg::seg_hdr_t o_tx_seg,
    output logic              o_tx_seg_valid,
    input  logic              i_tx_seg_ready
);
    import tcp_pkg::*;

    logic                       enable;
    logic [N_CONN-1:0]          open_req;
    logic [N_CONN-1:0]          close_req;
    logic [N_CONN-1:0]          open_clr;
    logic [N_CONN-1:0]          close_clr;
    conn_state_vec_t            state_vec;
    rx_msg_t                    rx_msg;
    logic [N_CONN-1:0]          rx_msg_valid;
    logic [N_CONN-1:0]          rx_msg_ack;
    tx_ctrl_t [N_CONN-1:0]      tx_req;
    logic [N_CONN-1:0]          tx_req_valid;
    logic [N_CONN-1:0]          tx_req_ack;

    tcp_host_regs regs_i (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
        .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
        .o_enable(enable), .o_open(open_req), .o_close(close_req),
        .i_open_clr(open_clr), .i_close_clr(close_clr), .i_state(state_vec)
    );

    tcp_rx_classifier rx_cls_i (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_rx_seg(i_rx_seg), .i_rx_seg_valid(i_rx_seg_valid), .o_rx_seg_ready(o_rx_seg_ready),
        .o_msg(rx_msg), .o_msg_valid(rx_msg_valid), .i_msg_ack(rx_msg_ack)
    );

    for (genvar i = 0; i < N_CONN; i++) begin : g_conn
        tcp_conn_fsm fsm_i (
            .i_clk(i_clk), .i_rst(i_rst), .i_enable(enable),
            .i_open(open_req[i]), .o_open_clr(open_clr[i]),
            .i_close(close_req[i]), .o_close_clr(close_clr[i]),
            .o_tx_ctrl(tx_req[i]), .o_tx_ctrl_valid(tx_req_valid[i]),
            .i_tx_ctrl_ack(tx_req_ack[i]),
            .i_rx_msg(rx_msg), .i_rx_msg_valid(rx_msg_valid[i]), .o_rx_msg_ack(rx_msg_ack[i]),
            .o_state(state_vec[i])
        );
    end

    tcp_tx_arbiter tx_arb_i (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_req(tx_req), .i_req_valid(tx_req_valid), .o_req_ack(tx_req_ack),
        .o_tx_seg(o_tx_seg), .o_tx_seg_valid(o_tx_seg_valid), .i_tx_seg_ready(i_tx_seg_ready)
    );

endmodule

// ==== tb_tcp_conn_engine.sv ====
`timescale 1ns/1ps

module tb_tcp_conn_engine;
    import tcp_pkg::*;

    // Upper bound on the length of the whole run.
    localparam int MAX_CYCLES = 3000;
    localparam int WAIT_LIMIT = 200;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_wdat;
    logic [31:0] wb_rdat;
    logic        wb_ack;
    seg_hdr_t    rx_seg;
    logic        rx_valid;
    logic        rx_ready;
    seg_hdr_t    tx_seg;
    logic        tx_valid;
    logic        tx_ready;
    int          cycle_cnt = 0;

    tcp_conn_engine dut_i (
        .i_clk(clk), .i_rst(rst),
        .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
        .i_wb_adr(wb_adr), .i_wb_dat(wb_wdat), .o_wb_dat(wb_rdat), .o_wb_ack(wb_ack),
        .i_rx_seg(rx_seg), .i_rx_seg_valid(rx_valid), .o_rx_seg_ready(rx_ready),
        .o_tx_seg(tx_seg), .o_tx_seg_valid(tx_valid), .i_tx_seg_ready(tx_ready)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            fail_run("Run stopped: the cycle limit was reached before the tests finished.");
        end
    end

    task automatic check_seg(input string name, input seg_hdr_t act, input seg_hdr_t exp);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, act, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] act,
                              input logic [31:0] exp);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, act, exp));
        end
    endtask

    task automatic check_state(input string name, input conn_state_e act,
                               input conn_state_e exp);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, act, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, act, exp));
        end
    endtask

    function automatic seg_hdr_t make_seg(input int id, input logic syn, input logic ack,
                                          input logic fin);
        seg_hdr_t seg;
        seg.conn_id = CONN_ID_W'(id);
        seg.syn     = syn;
        seg.ack     = ack;
        seg.fin     = fin;
        return seg;
    endfunction

    // One classic bus cycle; ack is sampled away from the clock edge.
    task automatic wb_cycle(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
        int n;
        n = 0;
        @(posedge clk);
        wb_cyc  <= 1'b1;
        wb_stb  <= 1'b1;
        wb_we   <= we;
        wb_adr  <= adr;
        wb_wdat <= wdat;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) fail_run("The Wishbone slave never returned ack.");
        end while (!wb_ack);
        rdat = wb_rdat;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        if (wb_ack) fail_run("The Wishbone ack stayed high for more than one cycle.");
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
        wb_cycle(1'b0, adr, '0, dat);
    endtask

    task automatic send_seg(input seg_hdr_t seg);
        int n;
        n = 0;
        @(posedge clk);
        rx_seg   <= seg;
        rx_valid <= 1'b1;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) fail_run("The incoming stream never became ready.");
        end while (!rx_ready);
        @(posedge clk);
        rx_valid <= 1'b0;
    endtask

    // Ready stays low until the header has been checked and held for stall cycles.
    task automatic expect_seg(input seg_hdr_t exp, input int stall);
        int n;
        int i;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) fail_run("An expected outgoing segment never appeared.");
        end while (!tx_valid);
        check_seg("o_tx_seg", tx_seg, exp);
        for (i = 0; i < stall; i++) begin
            @(negedge clk);
            if (!tx_valid) fail_run("The outgoing valid dropped while ready was low.");
            check_seg("o_tx_seg", tx_seg, exp);
        end
        @(posedge clk);
        tx_ready <= 1'b1;
        @(posedge clk);
        tx_ready <= 1'b0;
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (tx_valid) fail_run("An outgoing segment appeared when none was expected.");
        end
    endtask

    task automatic read_state(input int id, input conn_state_e exp);
        logic [31:0] word;
        wb_read(REG_STATUS, word);
        check_state($sformatf("state[%0d]", id), conn_state_e'(word[4*id +: 4]), exp);
    endtask

    task automatic wait_idle(input int id, input int limit);
        logic [31:0] word;
        int          start;
        start = cycle_cnt;
        wb_read(REG_STATUS, word);
        while (conn_state_e'(word[4*id +: 4]) != IDLE) begin
            if (cycle_cnt - start > limit) begin
                fail_run($sformatf("Connection %0d did not return to IDLE in time.", id));
            end
            wb_read(REG_STATUS, word);
        end
    endtask

    task automatic establish(input int id);
        wb_write(REG_CTRL, 32'(1) << id);
        expect_seg(make_seg(id, 1'b1, 1'b0, 1'b0), 0);
        send_seg(make_seg(id, 1'b1, 1'b1, 1'b0));
        expect_seg(make_seg(id, 1'b0, 1'b1, 1'b0), 0);
        read_state(id, ESTABLISHED);
    endtask

    task automatic test_reset_values();
        logic [31:0] word;
        @(negedge clk);
        check_bit("o_wb_ack", wb_ack, 1'b0);
        check_bit("o_tx_seg_valid", tx_valid, 1'b0);
        check_bit("o_rx_seg_ready", rx_ready, 1'b1);
        wb_read(REG_ENABLE, word);
        check_word("REG_ENABLE", word, 32'h0);
        wb_read(REG_CTRL, word);
        check_word("REG_CTRL", word, 32'h0);
        wb_read(REG_STATUS, word);
        check_word("REG_STATUS", word, 32'h0);
    endtask

    task automatic test_active_open();
        logic [31:0] word;
        wb_write(REG_ENABLE, 32'h1);
        wb_read(REG_ENABLE, word);
        check_word("REG_ENABLE", word, 32'h1);
        establish(1);
        wb_read(REG_CTRL, word);
        check_word("REG_CTRL", word, 32'h0);
    endtask

    task automatic test_active_close();
        logic [31:0] word;
        wb_write(REG_CTRL, 32'(1) << (CTRL_CLOSE_LSB + 1));
        expect_seg(make_seg(1, 1'b0, 1'b1, 1'b1), 0);
        wb_read(REG_CTRL, word);
        check_word("REG_CTRL", word, 32'h0);
        read_state(1, FIN_WAIT_1);
        send_seg(make_seg(1, 1'b0, 1'b1, 1'b0));
        read_state(1, FIN_WAIT_2);
        send_seg(make_seg(1, 1'b0, 1'b0, 1'b1));
        expect_seg(make_seg(1, 1'b0, 1'b1, 1'b0), 0);
        wait_idle(1, 20);
    endtask

    task automatic test_passive_close();
        establish(2);
        // Peer FIN carries ACK as well.
        send_seg(make_seg(2, 1'b0, 1'b1, 1'b1));
        expect_seg(make_seg(2, 1'b0, 1'b1, 1'b0), 0);
        expect_seg(make_seg(2, 1'b0, 1'b1, 1'b1), 0);
        read_state(2, LAST_ACK);
        send_seg(make_seg(2, 1'b0, 1'b1, 1'b0));
        read_state(2, IDLE);
    endtask

    task automatic test_simultaneous_close();
        logic [31:0] word;
        establish(3);
        wb_write(REG_CTRL, 32'(1) << (CTRL_CLOSE_LSB + 3));
        expect_seg(make_seg(3, 1'b0, 1'b1, 1'b1), 0);
        read_state(3, FIN_WAIT_1);
        send_seg(make_seg(3, 1'b0, 1'b0, 1'b1));
        expect_seg(make_seg(3, 1'b0, 1'b1, 1'b0), 0);
        wait_idle(3, 20);
        // Stray headers. None may change a state or produce output.
        send_seg(make_seg(3, 1'b0, 1'b0, 1'b0));
        send_seg(make_seg(0, 1'b0, 1'b1, 1'b0));
        send_seg(make_seg(1, 1'b0, 1'b0, 1'b1));
        send_seg(make_seg(2, 1'b1, 1'b1, 1'b0));
        send_seg(make_seg(0, 1'b1, 1'b0, 1'b0));
        expect_quiet(10);
        wb_read(REG_STATUS, word);
        check_word("REG_STATUS", word, 32'h0);
    endtask

    task automatic test_arbitration();
        logic [31:0] word;
        logic [31:0] exp_word;
        int          stall;
        int          i;
        stall = int'($urandom_range(8, 1));
        wb_write(REG_CTRL, 32'h0000_000f);
        expect_seg(make_seg(0, 1'b1, 1'b0, 1'b0), stall);
        for (i = 1; i < N_CONN; i++) begin
            expect_seg(make_seg(i, 1'b1, 1'b0, 1'b0), 0);
        end
        exp_word = '0;
        for (i = 0; i < N_CONN; i++) begin
            exp_word[4*i +: 4] = SYN_SENT_1;
        end
        wb_read(REG_STATUS, word);
        check_word("REG_STATUS", word, exp_word);
    endtask

    task automatic test_disable();
        logic [31:0] word;
        send_seg(make_seg(0, 1'b1, 1'b1, 1'b0));
        expect_seg(make_seg(0, 1'b0, 1'b1, 1'b0), 0);
        send_seg(make_seg(2, 1'b1, 1'b1, 1'b0));
        expect_seg(make_seg(2, 1'b0, 1'b1, 1'b0), 0);
        wb_write(REG_CTRL, 32'(1) << (CTRL_CLOSE_LSB + 2));
        expect_seg(make_seg(2, 1'b0, 1'b1, 1'b1), 0);
        read_state(0, ESTABLISHED);
        read_state(1, SYN_SENT_1);
        read_state(2, FIN_WAIT_1);
        wb_write(REG_ENABLE, 32'h0);
        wb_read(REG_STATUS, word);
        check_word("REG_STATUS", word, 32'h0);
        expect_quiet(20);
    endtask

    initial begin
        void'($urandom(32'hd3b1));
        clk      = 1'b0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_wdat  = '0;
        rx_seg   = '0;
        rx_valid = 1'b0;
        tx_ready = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        test_reset_values();
        test_active_open();
        test_active_close();
        test_passive_close();
        test_simultaneous_close();
        test_arbitration();
        test_disable();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
tcp_pkg.sv
tcp_conn_fsm.sv
tcp_rx_classifier.sv
tcp_tx_arbiter.sv
tcp_host_regs.sv
tcp_conn_engine.sv
tb_tcp_conn_engine.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_tcp_conn_engine -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_tcp_conn_engine)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with an error status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
echo "Pass message not found"
exit 1
